// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu5stage_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal

SOURCES := $(wildcard source/*.sv source/*.svh dv/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+source
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/cpu5stage.sv
dv/cpu5stage_props.sv
dv/cpu5stage_tb.sv

// ==== dv/cpu5stage_props.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu5stage_props (
	input logic                 input_clk,
	input logic                 rst,
	input logic                 stall,
	input logic                 exc,
	input cpu_pkg::redirect_t   redirect,
	input cpu_pkg::id_ex_t      id_ex,
	input logic                 halted,
	input logic [`CPU_XLEN-1:0] cycles_consumed
);

	// ========================================================================
	// pipeline control
	// ========================================================================

	bubble_on_hold: assert property (@(posedge input_clk) disable iff (rst)
		(!halted && (stall || redirect.taken || exc)) |=> !id_ex.valid)
		else $error("decode passed a valid instruction on a stall, redirect or exception");

	halt_sticky: assert property (@(posedge input_clk) disable iff (rst)
		halted |=> halted)
		else $error("halted dropped without a reset");

	cycles_frozen: assert property (@(posedge input_clk) disable iff (rst)
		halted |=> $stable(cycles_consumed))
		else $error("cycles_consumed moved while halted");

	// nothing in flight can steer fetch right after reset
	quiet_after_reset: assert property (@(posedge input_clk)
		rst |=> (!redirect.taken && !exc))
		else $error("redirect or exc raised in the cycle after reset");

endmodule

// ==== dv/cpu5stage_tb.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu5stage_tb;

	localparam logic [31:0] ECALL = 32'h0000_0073;
	localparam logic [31:0] MARKER = 32'h0000_00AA;

	logic                   input_clk;
	logic                   rst;
	logic [`CPU_MEM_AW-1:0] host_addr;
	logic [`CPU_XLEN-1:0]   host_wdata;
	logic                   host_imem_we;
	logic                   host_dmem_we;
	logic [`CPU_XLEN-1:0]   host_rdata;
	logic [`CPU_XLEN-1:0]   pc;
	logic [`CPU_XLEN-1:0]   cycles_consumed;
	logic                   halted;

	logic [31:0] lfsr = 32'h8bf19a49;
	logic [31:0] prog [$];

	cpu5stage u_dut (
		.input_clk      (input_clk),
		.rst            (rst),
		.host_addr      (host_addr),
		.host_wdata     (host_wdata),
		.host_imem_we   (host_imem_we),
		.host_dmem_we   (host_dmem_we),
		.host_rdata     (host_rdata),
		.pc             (pc),
		.cycles_consumed(cycles_consumed),
		.halted         (halted)
	);

	bind cpu5stage cpu5stage_props u_props (
		.input_clk      (input_clk),
		.rst            (rst),
		.stall          (stall),
		.exc            (exc),
		.redirect       (redirect),
		.id_ex          (id_ex),
		.halted         (halted),
		.cycles_consumed(cycles_consumed)
	);

	always #5 input_clk = ~input_clk;

	// ========================================================================
	// random bits and instruction encoding
	// ========================================================================

	function automatic logic lfsr_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 32'hA300_0000;
		end
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_bit()};
		end
		return r;
	endfunction

	function automatic logic [31:0] fill_word(input int a);
		return {8'hC3, a[7:0], ~a[7:0], a[7:0] ^ 8'h5A};
	endfunction

	function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
	endfunction

	function automatic logic [31:0] add_imm(input int rd, input int rs1, input logic [11:0] imm);
		return {imm, 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
	endfunction

	function automatic logic [31:0] load_word(input int rd, input int rs1, input logic [11:0] imm);
		return {imm, 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
	endfunction

	function automatic logic [31:0] store_word(input int rs2, input int rs1,
		input logic [11:0] imm);
		return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
	endfunction

	// offsets count words, so w holds imm[12:1] of the usual B format
	function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, input int rs2,
		input logic [11:0] w);
		return {w[11], w[9:4], 5'(rs2), 5'(rs1), f3, w[3:0], w[10], 7'b1100011};
	endfunction

	function automatic logic [31:0] jump(input int rd, input logic [19:0] w);
		return {w[19], w[9:0], w[10], w[18:11], 5'(rd), 7'b1101111};
	endfunction

	// ========================================================================
	// host access, checks and run control
	// ========================================================================

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_now($sformatf("mismatch %s got 0x%08h expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic host_write(input logic to_imem, input int addr, input logic [31:0] data);
		@(posedge input_clk);
		host_imem_we <= to_imem;
		host_dmem_we <= !to_imem;
		host_addr <= addr[`CPU_MEM_AW-1:0];
		host_wdata <= data;
		@(posedge input_clk);
		host_imem_we <= 1'b0;
		host_dmem_we <= 1'b0;
	endtask

	task automatic start_program();
		@(posedge input_clk);
		rst <= 1'b1;
		repeat (16) @(posedge input_clk);
		for (int a = 0; a < `CPU_DMEM_WORDS; a++) begin
			host_write(1'b0, a, fill_word(a));
		end
		foreach (prog[i]) begin
			host_write(1'b1, i, prog[i]);
		end
	endtask

	task automatic run_to_halt(input int limit);
		int n;
		@(posedge input_clk);
		rst <= 1'b0;
		n = 0;
		@(negedge input_clk);
		while (!halted && n < limit) begin
			@(negedge input_clk);
			n++;
		end
		if (!halted) begin
			fail_now("the core did not halt before the timeout");
		end
	endtask

	// data memory answers one cycle after the address
	task automatic expect_word(input int addr, input logic [31:0] exp);
		@(posedge input_clk);
		host_addr <= addr[`CPU_MEM_AW-1:0];
		@(posedge input_clk);
		@(negedge input_clk);
		check($sformatf("dmem[%0d]", addr), host_rdata, exp);
	endtask

	// ========================================================================
	// directed tests
	// ========================================================================

	task automatic alu_results();
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		logic [31:0] want [3:10];
		a = rand_bits(32);
		b = rand_bits(32);
		imm = 12'(rand_bits(12));
		want[3] = a + b;
		want[4] = a - b;
		want[5] = a & b;
		want[6] = a | b;
		want[7] = a ^ b;
		want[8] = {31'b0, $signed(a) < $signed(b)};
		want[9] = {31'b0, $signed(b) < $signed(a)};
		want[10] = a + {{20{imm[11]}}, imm};
		prog.delete();
		prog.push_back(load_word(1, 0, 12'd16));
		prog.push_back(load_word(2, 0, 12'd17));
		prog.push_back(rtype(7'h00, 3'b000, 3, 1, 2));
		prog.push_back(rtype(7'h20, 3'b000, 4, 1, 2));
		prog.push_back(rtype(7'h00, 3'b111, 5, 1, 2));
		prog.push_back(rtype(7'h00, 3'b110, 6, 1, 2));
		prog.push_back(rtype(7'h00, 3'b100, 7, 1, 2));
		prog.push_back(rtype(7'h00, 3'b010, 8, 1, 2));
		prog.push_back(rtype(7'h00, 3'b010, 9, 2, 1));
		prog.push_back(add_imm(10, 1, imm));
		prog.push_back(add_imm(0, 1, imm)); // x0 keeps reading zero
		for (int r = 3; r <= 10; r++) begin
			prog.push_back(store_word(r, 0, 12'(29 + r)));
		end
		prog.push_back(store_word(0, 0, 12'd40));
		prog.push_back(ECALL);
		start_program();
		host_write(1'b0, 16, a);
		host_write(1'b0, 17, b);
		run_to_halt(200);
		for (int r = 3; r <= 10; r++) begin
			expect_word(29 + r, want[r]);
		end
		expect_word(40, 32'h0);
	endtask

	task automatic forwarding_chain();
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		logic [31:0] v [3:9];
		a = rand_bits(32);
		b = rand_bits(32);
		imm = 12'(rand_bits(12));
		v[3] = a + b;
		v[4] = v[3] - a;
		v[5] = v[4] + {{20{imm[11]}}, imm};
		v[6] = v[3] ^ v[4];
		v[7] = v[5] | v[6];
		v[8] = 32'd1;
		v[9] = v[6] & v[7];
		prog.delete();
		prog.push_back(load_word(1, 0, 12'd16));
		prog.push_back(load_word(2, 0, 12'd17));
		prog.push_back(rtype(7'h00, 3'b000, 3, 1, 2));
		prog.push_back(rtype(7'h20, 3'b000, 4, 3, 1)); // x3 one back
		prog.push_back(add_imm(5, 4, imm));
		prog.push_back(rtype(7'h00, 3'b100, 6, 3, 4)); // x3 three back, x4 two back
		prog.push_back(rtype(7'h00, 3'b110, 7, 5, 6));
		prog.push_back(add_imm(8, 0, 12'd1));
		prog.push_back(rtype(7'h00, 3'b111, 9, 6, 7));
		prog.push_back(store_word(9, 0, 12'd57));
		for (int r = 3; r <= 8; r++) begin
			prog.push_back(store_word(r, 0, 12'(48 + r)));
		end
		prog.push_back(ECALL);
		start_program();
		host_write(1'b0, 16, a);
		host_write(1'b0, 17, b);
		run_to_halt(200);
		for (int r = 3; r <= 9; r++) begin
			expect_word(48 + r, v[r]);
		end
	endtask

	task automatic load_then_use();
		logic [31:0] v;
		v = rand_bits(32);
		prog.delete();
		prog.push_back(add_imm(1, 0, 12'd20));
		prog.push_back(load_word(2, 1, 12'd0));
		prog.push_back(add_imm(3, 2, 12'd1)); // needs the load one cycle late
		prog.push_back(store_word(3, 1, 12'd1));
		prog.push_back(load_word(4, 1, 12'd0));
		prog.push_back(store_word(4, 1, 12'd2));
		prog.push_back(ECALL);
		start_program();
		host_write(1'b0, 20, v);
		run_to_halt(200);
		expect_word(20, v);
		expect_word(21, v + 32'd1);
		expect_word(22, v);
	endtask

	task automatic branch_and_jump();
		prog.delete();
		prog.push_back(add_imm(1, 0, 12'd5));
		prog.push_back(add_imm(2, 0, 12'd5));
		prog.push_back(add_imm(3, 0, 12'd9));
		prog.push_back(add_imm(10, 0, MARKER[11:0]));
		prog.push_back(branch(3'b000, 1, 2, 12'd3)); // taken to word 7
		prog.push_back(store_word(10, 0, 12'd64));
		prog.push_back(store_word(10, 0, 12'd65));
		prog.push_back(branch(3'b001, 1, 2, 12'd3));
		prog.push_back(store_word(10, 0, 12'd66));
		prog.push_back(branch(3'b000, 1, 3, 12'd2));
		prog.push_back(store_word(10, 0, 12'd67));
		prog.push_back(branch(3'b001, 1, 3, 12'd3)); // taken to word 14
		prog.push_back(store_word(10, 0, 12'd68));
		prog.push_back(store_word(10, 0, 12'd69));
		prog.push_back(jump(5, 20'd3));
		prog.push_back(store_word(10, 0, 12'd70));
		prog.push_back(store_word(10, 0, 12'd71));
		prog.push_back(store_word(5, 0, 12'd72));
		prog.push_back(ECALL);
		start_program();
		run_to_halt(200);
		expect_word(64, fill_word(64));
		expect_word(65, fill_word(65));
		expect_word(66, MARKER);
		expect_word(67, MARKER);
		for (int a = 68; a <= 71; a++) begin
			expect_word(a, fill_word(a));
		end
		expect_word(72, 32'd15);
	endtask

	task automatic illegal_opcode();
		prog.delete();
		prog.push_back(add_imm(5, 0, 12'h123));
		prog.push_back(add_imm(6, 0, 12'h03C));
		prog.push_back(32'hFFFF_FFFF);
		prog.push_back(store_word(5, 0, 12'd80));
		prog.push_back(store_word(5, 0, 12'd81));
		prog.push_back(ECALL);
		start_program();
		host_write(1'b1, `CPU_HANDLER_ADDR, store_word(6, 0, 12'd82));
		host_write(1'b1, `CPU_HANDLER_ADDR + 1, ECALL);
		run_to_halt(200);
		expect_word(80, fill_word(80));
		expect_word(81, fill_word(81));
		expect_word(82, 32'h0000_003C);
	endtask

	task automatic halt_freeze();
		logic [31:0] pc_seen;
		logic [31:0] cycles_seen;
		prog.delete();
		prog.push_back(add_imm(1, 0, 12'd3));
		prog.push_back(add_imm(2, 1, 12'd4));
		prog.push_back(store_word(2, 0, 12'd90));
		prog.push_back(ECALL);
		start_program();
		run_to_halt(200);
		expect_word(90, 32'd7);
		pc_seen = pc;
		cycles_seen = cycles_consumed;
		if (cycles_seen == 32'd0) begin
			fail_now("cycles_consumed stayed at zero through a whole program");
		end
		repeat (20) begin
			@(negedge input_clk);
			check("pc", pc, pc_seen);
			check("cycles_consumed", cycles_consumed, cycles_seen);
		end
		@(posedge input_clk);
		rst <= 1'b1;
		@(posedge input_clk);
		@(negedge input_clk);
		check("cycles_consumed", cycles_consumed, 32'd0);
		check("halted", {31'b0, halted}, 32'd0);
		check("pc", pc, 32'd0);
	endtask

	initial begin
		input_clk = 1'b0;
		rst = 1'b1;
		host_addr = '0;
		host_wdata = '0;
		host_imem_we = 1'b0;
		host_dmem_we = 1'b0;
		alu_results();
		forwarding_chain();
		load_then_use();
		branch_and_jump();
		illegal_opcode();
		halt_freeze();
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== source/cpu5stage.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu5stage (
	input  logic                   input_clk,
	input  logic                   rst,
	input  logic [`CPU_MEM_AW-1:0] host_addr,
	input  logic [`CPU_XLEN-1:0]   host_wdata,
	input  logic                   host_imem_we,
	input  logic                   host_dmem_we,
	output logic [`CPU_XLEN-1:0]   host_rdata,
	output logic [`CPU_XLEN-1:0]   pc,
	output logic [`CPU_XLEN-1:0]   cycles_consumed,
	output logic                   halted
);
	import cpu_pkg::*;

	if_id_t    if_id;
	id_ex_t    id_ex;
	ex_res_t   ex_res;
	wb_t       wb;
	redirect_t redirect;
	logic      stall;
	logic      exc;

	fetch_stage u_fetch (
		.input_clk   (input_clk),
		.rst         (rst),
		.stall       (stall),
		.redirect    (redirect),
		.exc         (exc),
		.halted      (halted),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.host_imem_we(host_imem_we),
		.pc          (pc),
		.if_id       (if_id)
	);

	decode_stage u_decode (
		.input_clk(input_clk),
		.rst      (rst),
		.if_id    (if_id),
		.wb       (wb),
		.ex_res   (ex_res),
		.redirect (redirect),
		.halted   (halted),
		.id_ex    (id_ex),
		.stall    (stall),
		.exc      (exc)
	);

	execute_stage u_execute (
		.input_clk(input_clk),
		.rst      (rst),
		.id_ex    (id_ex),
		.wb       (wb),
		.halted   (halted),
		.ex_res   (ex_res),
		.redirect (redirect)
	);

	result_stage u_result (
		.input_clk      (input_clk),
		.rst            (rst),
		.ex_res         (ex_res),
		.host_addr      (host_addr),
		.host_wdata     (host_wdata),
		.host_dmem_we   (host_dmem_we),
		.host_rdata     (host_rdata),
		.wb             (wb),
		.halted         (halted),
		.cycles_consumed(cycles_consumed)
	);

endmodule

// ==== source/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ========================================================================
// core widths and memory sizes
// ========================================================================

`define CPU_XLEN 32

// both memories are word addressed and share the host index width
`define CPU_IMEM_WORDS 256
`define CPU_DMEM_WORDS 256
`define CPU_MEM_AW $clog2(`CPU_DMEM_WORDS)

// fetch restarts here after an illegal opcode
`define CPU_HANDLER_ADDR 32'h0000_00FE

`endif

// ==== source/cpu_pkg.sv ====
`include "cpu_consts.svh"

package cpu_pkg;

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		SYSTEM = 7'b1110011 // ecall encoding, taken as halt
	} opcode_e;

	typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLT} alu_op_e;

	// ====================================================================
	// instruction word views
	// ====================================================================

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_r_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} inst_sb_t;

	typedef union packed {
		inst_r_t  r;  // R and I formats, also read for the J immediate
		inst_sb_t sb; // S and B formats with the split immediate
	} inst_u;

	// ====================================================================
	// pipeline registers
	// ====================================================================

	typedef struct packed {
		logic                 valid;
		logic [`CPU_XLEN-1:0] pc;
		inst_u                inst;
	} if_id_t;

	typedef struct packed {
		logic                 valid;
		logic [`CPU_XLEN-1:0] pc;
		alu_op_e              alu_op;
		logic [4:0]           rs1;
		logic [4:0]           rs2;
		logic [4:0]           rd;
		logic [`CPU_XLEN-1:0] rs1_val;
		logic [`CPU_XLEN-1:0] rs2_val;
		logic [`CPU_XLEN-1:0] imm;
		logic                 use_imm;
		logic                 reg_write;
		logic                 mem_read;
		logic                 mem_write;
		logic                 is_branch;
		logic                 branch_ne;
		logic                 is_jal;
		logic                 is_halt;
	} id_ex_t;

	typedef struct packed {
		logic                 valid;
		logic [4:0]           rd;
		logic                 reg_write;
		logic                 mem_read;
		logic                 mem_write;
		logic                 is_halt;
		logic [`CPU_XLEN-1:0] alu_result; // also the word address of loads and stores
		logic [`CPU_XLEN-1:0] store_data;
	} ex_res_t;

	typedef struct packed {
		logic                 valid;
		logic [4:0]           rd;
		logic                 reg_write;
		logic [`CPU_XLEN-1:0] wdata;
	} wb_t;

	typedef struct packed {
		logic                 taken;
		logic [`CPU_XLEN-1:0] target;
	} redirect_t;

endpackage

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_stage (
	input  logic               input_clk,
	input  logic               rst,
	input  cpu_pkg::if_id_t    if_id,
	input  cpu_pkg::wb_t       wb,
	input  cpu_pkg::ex_res_t   ex_res,
	input  cpu_pkg::redirect_t redirect,
	input  logic               halted,
	output cpu_pkg::id_ex_t    id_ex,
	output logic               stall,
	output logic               exc
);
	import cpu_pkg::*;

	logic [`CPU_XLEN-1:0] regs [0:31];
	logic                 wb_we;
	opcode_e              opcode;
	id_ex_t               dec;
	logic                 illegal;
	logic                 uses_rs1;
	logic                 uses_rs2;
	logic                 halt_ahead;

	// ========================================================================
	// register file, x0 reads zero and a same-cycle write is seen at once
	// ========================================================================

	assign wb_we = !halted && wb.valid && wb.reg_write && (wb.rd != 5'd0);

	always_ff @(posedge input_clk) begin
		if (wb_we) begin
			regs[wb.rd] <= wb.wdata;
		end
	end

	function automatic logic [`CPU_XLEN-1:0] read_reg(input logic [4:0] idx);
		logic [`CPU_XLEN-1:0] val;
		if (idx == 5'd0) begin
			val = '0;
		end else if (wb_we && (wb.rd == idx)) begin
			val = wb.wdata;
		end else begin
			val = regs[idx];
		end
		return val;
	endfunction

	function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic sub);
		case (funct3)
			3'b100: return XOR;
			3'b110: return OR;
			3'b111: return AND;
			3'b010: return SLT;
			default: return sub ? SUB : ADD;
		endcase
	endfunction

	// ========================================================================
	// control and immediates
	// ========================================================================

	assign opcode = opcode_e'(if_id.inst.r.opcode);

	always_comb begin
		dec = '0;
		illegal = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		dec.pc = if_id.pc;
		dec.rd = if_id.inst.r.rd;
		dec.rs1 = if_id.inst.r.rs1;
		dec.rs2 = if_id.inst.r.rs2;
		dec.rs1_val = read_reg(if_id.inst.r.rs1);
		dec.rs2_val = read_reg(if_id.inst.r.rs2);
		dec.alu_op = ADD; // address add for loads and stores
		case (opcode)
			OP: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				dec.reg_write = 1'b1;
				dec.alu_op = alu_decode(if_id.inst.r.funct3, if_id.inst.r.funct7[5]);
			end
			OP_IMM: begin
				uses_rs1 = 1'b1;
				dec.reg_write = 1'b1;
				dec.use_imm = 1'b1;
				dec.imm = {{20{if_id.inst.r.funct7[6]}}, if_id.inst.r.funct7, if_id.inst.r.rs2};
				dec.alu_op = alu_decode(if_id.inst.r.funct3, 1'b0);
			end
			LOAD: begin
				uses_rs1 = 1'b1;
				dec.reg_write = 1'b1;
				dec.mem_read = 1'b1;
				dec.use_imm = 1'b1;
				dec.imm = {{20{if_id.inst.r.funct7[6]}}, if_id.inst.r.funct7, if_id.inst.r.rs2};
			end
			STORE: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				dec.mem_write = 1'b1;
				dec.use_imm = 1'b1;
				dec.imm = {{20{if_id.inst.sb.imm_hi[6]}}, if_id.inst.sb.imm_hi,
					if_id.inst.sb.imm_lo};
			end
			BRANCH: begin // offsets count words, so the implicit low zero is dropped
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				dec.is_branch = 1'b1;
				dec.branch_ne = if_id.inst.sb.funct3[0];
				dec.imm = {{20{if_id.inst.sb.imm_hi[6]}}, if_id.inst.sb.imm_hi[6],
					if_id.inst.sb.imm_lo[0], if_id.inst.sb.imm_hi[5:0], if_id.inst.sb.imm_lo[4:1]};
			end
			JAL: begin
				dec.reg_write = 1'b1;
				dec.is_jal = 1'b1;
				dec.imm = {{12{if_id.inst.r.funct7[6]}}, if_id.inst.r.funct7[6], if_id.inst.r.rs1,
					if_id.inst.r.funct3, if_id.inst.r.rs2[0], if_id.inst.r.funct7[5:0],
					if_id.inst.r.rs2[4:1]};
			end
			SYSTEM: begin
				dec.is_halt = 1'b1;
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

	// words fetched behind a retiring halt must not send fetch to the handler
	assign halt_ahead = (id_ex.valid && id_ex.is_halt) || (ex_res.valid && ex_res.is_halt);

	assign stall = if_id.valid && id_ex.valid && id_ex.mem_read && (id_ex.rd != 5'd0) &&
		((uses_rs1 && (if_id.inst.r.rs1 == id_ex.rd)) || (uses_rs2 && (if_id.inst.r.rs2 == id_ex.rd)));
	assign exc = if_id.valid && illegal && !halt_ahead;

	always_ff @(posedge input_clk) begin
		if (rst) begin
			id_ex.valid <= 1'b0;
		end else if (!halted) begin
			id_ex <= dec;
			id_ex.valid <= if_id.valid && !illegal && !stall && !redirect.taken;
		end
	end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module execute_stage (
	input  logic               input_clk,
	input  logic               rst,
	input  cpu_pkg::id_ex_t    id_ex,
	input  cpu_pkg::wb_t       wb,
	input  logic               halted,
	output cpu_pkg::ex_res_t   ex_res,
	output cpu_pkg::redirect_t redirect
);
	import cpu_pkg::*;

	logic [`CPU_XLEN-1:0] op_a;
	logic [`CPU_XLEN-1:0] op_b;
	logic [`CPU_XLEN-1:0] alu_b;
	logic [`CPU_XLEN-1:0] alu_y;
	ex_res_t              nxt;

	// the memory stage result is younger than writeback, so it is checked first
	function automatic logic [`CPU_XLEN-1:0] forward(input logic [4:0] idx,
		input logic [`CPU_XLEN-1:0] rf_val);
		logic [`CPU_XLEN-1:0] val;
		val = rf_val;
		if (idx != 5'd0) begin
			if (ex_res.valid && ex_res.reg_write && (ex_res.rd == idx)) begin
				val = ex_res.alu_result;
			end else if (wb.valid && wb.reg_write && (wb.rd == idx)) begin
				val = wb.wdata;
			end
		end
		return val;
	endfunction

	always_comb begin
		op_a = forward(id_ex.rs1, id_ex.rs1_val);
		op_b = forward(id_ex.rs2, id_ex.rs2_val);
		alu_b = id_ex.use_imm ? id_ex.imm : op_b;
		case (id_ex.alu_op)
			SUB: alu_y = op_a - alu_b;
			AND: alu_y = op_a & alu_b;
			OR: alu_y = op_a | alu_b;
			XOR: alu_y = op_a ^ alu_b;
			SLT: alu_y = {{(`CPU_XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			default: alu_y = op_a + alu_b;
		endcase
	end

	always_comb begin
		redirect.taken = id_ex.valid &&
			(id_ex.is_jal || (id_ex.is_branch && ((op_a == op_b) != id_ex.branch_ne)));
		redirect.target = id_ex.pc + id_ex.imm;
	end

	always_comb begin
		nxt.valid = id_ex.valid;
		nxt.rd = id_ex.rd;
		nxt.reg_write = id_ex.reg_write;
		nxt.mem_read = id_ex.mem_read;
		nxt.mem_write = id_ex.mem_write;
		nxt.is_halt = id_ex.is_halt;
		nxt.alu_result = id_ex.is_jal ? id_ex.pc + 1'b1 : alu_y; // jal links the next word
		nxt.store_data = op_b;
	end

	always_ff @(posedge input_clk) begin
		if (rst) begin
			ex_res.valid <= 1'b0;
		end else if (!halted) begin
			ex_res <= nxt;
		end
	end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetch_stage (
	input  logic                   input_clk,
	input  logic                   rst,
	input  logic                   stall,
	input  cpu_pkg::redirect_t     redirect,
	input  logic                   exc,
	input  logic                   halted,
	input  logic [`CPU_MEM_AW-1:0] host_addr,
	input  logic [`CPU_XLEN-1:0]   host_wdata,
	input  logic                   host_imem_we,
	output logic [`CPU_XLEN-1:0]   pc,
	output cpu_pkg::if_id_t        if_id
);

	logic [`CPU_XLEN-1:0] imem [0:`CPU_IMEM_WORDS-1];

	always_ff @(posedge input_clk) begin
		if ((rst || halted) && host_imem_we) begin // host loads code only while the core is idle
			imem[host_addr] <= host_wdata;
		end
	end

	always_ff @(posedge input_clk) begin
		if (rst) begin
			pc <= '0;
			if_id.valid <= 1'b0;
		end else if (!halted) begin
			if (redirect.taken) begin // older than the exception, so it wins
				pc <= redirect.target;
				if_id.valid <= 1'b0;
			end else if (exc) begin
				pc <= `CPU_HANDLER_ADDR;
				if_id.valid <= 1'b0;
			end else if (!stall) begin
				pc <= pc + 1'b1;
				if_id.valid <= 1'b1;
				if_id.pc <= pc;
				if_id.inst <= imem[pc[`CPU_MEM_AW-1:0]];
			end
		end
	end

endmodule

// ==== source/result_stage.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module result_stage (
	input  logic                   input_clk,
	input  logic                   rst,
	input  cpu_pkg::ex_res_t       ex_res,
	input  logic [`CPU_MEM_AW-1:0] host_addr,
	input  logic [`CPU_XLEN-1:0]   host_wdata,
	input  logic                   host_dmem_we,
	output logic [`CPU_XLEN-1:0]   host_rdata,
	output cpu_pkg::wb_t           wb,
	output logic                   halted,
	output logic [`CPU_XLEN-1:0]   cycles_consumed
);
	import cpu_pkg::*;

	logic [`CPU_XLEN-1:0]   dmem [0:`CPU_DMEM_WORDS-1];
	logic [`CPU_XLEN-1:0]   mem_q;
	logic [`CPU_MEM_AW-1:0] mem_addr;
	logic                   host_mode;
	logic                   core_we;
	wb_t                    wb_q;
	logic                   load_q;

	// ========================================================================
	// data memory, owned by the host while the core is idle
	// ========================================================================

	assign host_mode = rst || halted;
	assign mem_addr = host_mode ? host_addr : ex_res.alu_result[`CPU_MEM_AW-1:0];
	assign core_we = !host_mode && ex_res.valid && ex_res.mem_write;

	always_ff @(posedge input_clk) begin
		if (host_mode && host_dmem_we) begin
			dmem[mem_addr] <= host_wdata;
		end else if (core_we) begin
			dmem[mem_addr] <= ex_res.store_data;
		end
		mem_q <= dmem[mem_addr];
	end

	assign host_rdata = mem_q;

	always_ff @(posedge input_clk) begin
		if (rst) begin
			wb_q.valid <= 1'b0;
			load_q <= 1'b0;
		end else if (!halted) begin
			wb_q <= '{valid: ex_res.valid, rd: ex_res.rd, reg_write: ex_res.reg_write,
				wdata: ex_res.alu_result};
			load_q <= ex_res.valid && ex_res.mem_read;
		end
	end

	always_comb begin
		wb = wb_q;
		if (load_q) begin // the memory output register already holds the loaded word
			wb.wdata = mem_q;
		end
	end

	always_ff @(posedge input_clk) begin
		if (rst) begin
			halted <= 1'b0;
			cycles_consumed <= '0;
		end else if (!halted) begin
			halted <= ex_res.valid && ex_res.is_halt;
			cycles_consumed <= cycles_consumed + 1'b1;
		end
	end

endmodule
